// ==== Bender.yml ====
package:
  name: spu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/spu_pkg.sv
      - rtl/spuRegisters.sv
      - rtl/spuNoiseSource.sv
      - rtl/spuVoice.sv
      - rtl/spuMixer.sv
      - rtl/spuTop.sv
  - target: test
    include_dirs:
      - rtl
      - test
    files:
      - test/tbSpu.sv

// ==== flist.f ====
+incdir+rtl
+incdir+test
rtl/spu_pkg.sv
rtl/spuRegisters.sv
rtl/spuNoiseSource.sv
rtl/spuVoice.sv
rtl/spuMixer.sv
rtl/spuTop.sv
test/tbSpu.sv

// ==== rtl/spuMixer.sv ====
// Sound processor stereo mixer with clamping, main volume and DAC strobe
`include "spu_settings.svh"

module spuMixer import spu_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_rst,
	input  logic    i_valid,
	input  sample_t i_sampleL [`SPU_VOICES],
	input  sample_t i_sampleR [`SPU_VOICES],
	input  volume_t i_mainVolL,
	input  volume_t i_mainVolR,
	output sample_t o_aoutL,
	output sample_t o_aoutR,
	output logic    o_validOut
);

	// Room for the full voice sum without wrapping
	localparam int ACC_W = 16 + $clog2(`SPU_VOICES) + 1;

	logic signed [ACC_W-1:0] sumL, sumR;
	sample_t                 clampL, clampR;
	logic signed [31:0]      scaledL, scaledR;

	// Saturate the accumulator to the signed 16 bit range
	function automatic sample_t clamp16(input logic signed [ACC_W-1:0] x);
		if (x > 32767)
			return 16'sh7FFF;
		else if (x < -32768)
			return 16'sh8000;
		else
			return sample_t'(x);
	endfunction

	always_comb
	begin
		sumL = '0;
		sumR = '0;
		for (int v = 0; v < `SPU_VOICES; v++)
		begin
			sumL = sumL + i_sampleL[v];
			sumR = sumR + i_sampleR[v];
		end
	end

	assign clampL  = clamp16(sumL);
	assign clampR  = clamp16(sumR);
	assign scaledL = clampL * i_mainVolL;
	assign scaledR = clampR * i_mainVolR;

	// DAC payload, only refreshed on a valid voice set
	always_ff @(posedge i_clk)
	begin
		if (i_valid)
		begin
			o_aoutL <= sample_t'(scaledL >>> 15);
			o_aoutR <= sample_t'(scaledR >>> 15);
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_validOut <= 1'b0;
		else
			o_validOut <= i_valid;
	end

	// One strobe per sample period, never back to back
	aSingleStrobe: assert property (@(posedge i_clk) disable iff (i_rst)
		o_validOut |=> !o_validOut)
		else $error("spuMixer: o_validOut high on consecutive cycles");

endmodule

// ==== rtl/spuNoiseSource.sv ====
// Sound processor sample-rate timer and shared noise generator with step divider
`include "spu_settings.svh"

module spuNoiseSource import spu_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic [15:0] i_noiseDiv,
	output logic        o_tick,
	output sample_t     o_noise
);

	localparam int TICK_W = $clog2(`SPU_SAMPLE_PERIOD);
	localparam logic [TICK_W-1:0] LAST_CYCLE = TICK_W'(`SPU_SAMPLE_PERIOD - 1);

	logic [TICK_W-1:0] periodCnt;
	logic [15:0]       divCnt;
	logic [15:0]       noiseReg;
	logic              feedback;

	// Inverted taps, so an all-zero register still starts moving
	assign feedback = ~(noiseReg[15] ^ noiseReg[12] ^ noiseReg[11] ^ noiseReg[10]);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			periodCnt <= '0;
			o_tick    <= 1'b0;
			divCnt    <= '0;
			noiseReg  <= '0;
		end
		else
		begin
			// Tick rises SPU_SAMPLE_PERIOD edges after reset, then once per period
			o_tick    <= (periodCnt == LAST_CYCLE);
			periodCnt <= (periodCnt == LAST_CYCLE) ? '0 : periodCnt + 1'b1;

			// Noise steps once every i_noiseDiv+1 ticks
			if (o_tick)
			begin
				if (divCnt >= i_noiseDiv)
				begin
					divCnt   <= '0;
					noiseReg <= {noiseReg[14:0], feedback};
				end
				else
					divCnt <= divCnt + 16'd1;
			end
		end
	end

	assign o_noise = sample_t'(noiseReg);

endmodule

// ==== rtl/spuRegisters.sv ====
// Sound processor CPU register file with key strobes and one-cycle read-back
`include "spu_settings.svh"

module spuRegisters import spu_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	// CPU side, 16 bit half-word accesses
	input  logic               i_cs,
	input  logic               i_rd,
	input  logic               i_wr,
	input  regIndex_t          i_addr,
	input  logic [15:0]        i_dataIn,
	output logic [15:0]        o_dataOut,
	output logic               o_dataOutValid,
	// Per-voice setup
	output volume_t            o_volL        [`SPU_VOICES],
	output volume_t            o_volR        [`SPU_VOICES],
	output envLevel_t          o_attackStep  [`SPU_VOICES],
	output envLevel_t          o_releaseStep [`SPU_VOICES],
	output logic [`SPU_VOICES-1:0] o_keyOn,
	output logic [`SPU_VOICES-1:0] o_keyOff,
	// Global setup
	output logic [15:0]        o_noiseDiv,
	output volume_t            o_mainVolL,
	output volume_t            o_mainVolR
);

	localparam int VOICE_REGS = 4 * `SPU_VOICES;
	localparam int VIDX_W     = $clog2(VOICE_REGS);

	// Whole words are kept so every register reads back what was written
	logic [15:0] voiceRegs [VOICE_REGS];
	logic [15:0] keyOnReg, keyOffReg, noiseReg, mainLReg, mainRReg;
	logic [15:0] readData;
	logic        wrEn, rdEn, isVoiceReg;

	assign wrEn       = i_cs & i_wr;
	assign rdEn       = i_cs & i_rd;
	assign isVoiceReg = (i_addr < regIndex_t'(VOICE_REGS));

	// ----------------------------------------------------------------------
	// Write side
	// ----------------------------------------------------------------------
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			for (int i = 0; i < VOICE_REGS; i++)
				voiceRegs[i] <= '0;
			keyOnReg  <= '0;
			keyOffReg <= '0;
			noiseReg  <= '0;
			mainLReg  <= '0;
			mainRReg  <= '0;
		end
		else if (wrEn)
		begin
			if (isVoiceReg)
				voiceRegs[i_addr[VIDX_W-1:0]] <= i_dataIn;
			else
			begin
				case (i_addr)
					regIndex_t'(`SPU_REG_KEYON):  keyOnReg  <= i_dataIn;
					regIndex_t'(`SPU_REG_KEYOFF): keyOffReg <= i_dataIn;
					regIndex_t'(`SPU_REG_NOISE):  noiseReg  <= i_dataIn;
					regIndex_t'(`SPU_REG_MAINL):  mainLReg  <= i_dataIn;
					regIndex_t'(`SPU_REG_MAINR):  mainRReg  <= i_dataIn;
					default: ;
				endcase
			end
		end
	end

	// Key strobes, one cycle after the write, only voices with a 1 bit
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_keyOn  <= '0;
			o_keyOff <= '0;
		end
		else
		begin
			o_keyOn  <= (wrEn && i_addr == regIndex_t'(`SPU_REG_KEYON)) ?
				i_dataIn[`SPU_VOICES-1:0] : '0;
			o_keyOff <= (wrEn && i_addr == regIndex_t'(`SPU_REG_KEYOFF)) ?
				i_dataIn[`SPU_VOICES-1:0] : '0;
		end
	end

	// Slot order per voice: left vol, right vol, attack step, release step
	always_comb
	begin
		for (int v = 0; v < `SPU_VOICES; v++)
		begin
			o_volL[v]        = volume_t'(voiceRegs[4*v]);
			o_volR[v]        = volume_t'(voiceRegs[4*v+1]);
			o_attackStep[v]  = voiceRegs[4*v+2][14:0];
			o_releaseStep[v] = voiceRegs[4*v+3][14:0];
		end
	end

	assign o_noiseDiv = noiseReg;
	assign o_mainVolL = volume_t'(mainLReg);
	assign o_mainVolR = volume_t'(mainRReg);

	// ----------------------------------------------------------------------
	// Read side, answers on the next clock exactly once
	// ----------------------------------------------------------------------
	always_comb
	begin
		readData = '0;
		if (isVoiceReg)
			readData = voiceRegs[i_addr[VIDX_W-1:0]];
		else
		begin
			case (i_addr)
				regIndex_t'(`SPU_REG_KEYON):  readData = keyOnReg;
				regIndex_t'(`SPU_REG_KEYOFF): readData = keyOffReg;
				regIndex_t'(`SPU_REG_NOISE):  readData = noiseReg;
				regIndex_t'(`SPU_REG_MAINL):  readData = mainLReg;
				regIndex_t'(`SPU_REG_MAINR):  readData = mainRReg;
				default:                      readData = '0;   // unmapped reads zero
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (rdEn)
			o_dataOut <= readData;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_dataOutValid <= 1'b0;
		else
			o_dataOutValid <= rdEn;
	end

	// CPU never reads and writes in the same access
	aNoRdWr: assert property (@(posedge i_clk) disable iff (i_rst)
		i_cs |-> !(i_rd && i_wr))
		else $error("spuRegisters: read and write strobes high together");

endmodule

// ==== rtl/spuTop.sv ====
// Sound processor top with register block, noise source, voice array and mixer
`include "spu_settings.svh"

module spuTop import spu_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	// CPU side
	input  logic        i_cs,
	input  logic        i_rd,
	input  logic        i_wr,
	input  regIndex_t   i_addr,
	input  logic [15:0] i_dataIn,
	output logic [15:0] o_dataOut,
	output logic        o_dataOutValid,
	// Audio DAC side
	output sample_t     o_aoutL,
	output sample_t     o_aoutR,
	output logic        o_validOut
);

	volume_t                 volL [`SPU_VOICES];
	volume_t                 volR [`SPU_VOICES];
	envLevel_t               attackStep  [`SPU_VOICES];
	envLevel_t               releaseStep [`SPU_VOICES];
	logic [`SPU_VOICES-1:0]  keyOn, keyOff;
	logic [15:0]             noiseDiv;
	volume_t                 mainVolL, mainVolR;
	logic                    tick;
	sample_t                 noise;
	sample_t                 sampleL [`SPU_VOICES];
	sample_t                 sampleR [`SPU_VOICES];
	logic [`SPU_VOICES-1:0]  voiceValid;

	spuRegisters uRegisters
	(
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_cs           (i_cs),
		.i_rd           (i_rd),
		.i_wr           (i_wr),
		.i_addr         (i_addr),
		.i_dataIn       (i_dataIn),
		.o_dataOut      (o_dataOut),
		.o_dataOutValid (o_dataOutValid),
		.o_volL         (volL),
		.o_volR         (volR),
		.o_attackStep   (attackStep),
		.o_releaseStep  (releaseStep),
		.o_keyOn        (keyOn),
		.o_keyOff       (keyOff),
		.o_noiseDiv     (noiseDiv),
		.o_mainVolL     (mainVolL),
		.o_mainVolR     (mainVolR)
	);

	spuNoiseSource uNoise
	(
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_noiseDiv (noiseDiv),
		.o_tick     (tick),
		.o_noise    (noise)
	);

	// ----------------------------------------------------------------------
	// Voice array sharing one tick and one noise word
	// ----------------------------------------------------------------------
	for (genvar v = 0; v < `SPU_VOICES; v++)
	begin : gVoice
		spuVoice uVoice
		(
			.i_clk         (i_clk),
			.i_rst         (i_rst),
			.i_tick        (tick),
			.i_noise       (noise),
			.i_keyOn       (keyOn[v]),
			.i_keyOff      (keyOff[v]),
			.i_volL        (volL[v]),
			.i_volR        (volR[v]),
			.i_attackStep  (attackStep[v]),
			.i_releaseStep (releaseStep[v]),
			.o_sampleL     (sampleL[v]),
			.o_sampleR     (sampleR[v]),
			.o_valid       (voiceValid[v])
		);
	end

	// Voice 0 speaks for the whole array
	spuMixer uMixer
	(
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_valid    (voiceValid[0]),
		.i_sampleL  (sampleL),
		.i_sampleR  (sampleR),
		.i_mainVolL (mainVolL),
		.i_mainVolR (mainVolR),
		.o_aoutL    (o_aoutL),
		.o_aoutR    (o_aoutR),
		.o_validOut (o_validOut)
	);

endmodule

// ==== rtl/spuVoice.sv ====
// Sound processor voice with linear attack/release envelope and stereo volume weighting
`include "spu_settings.svh"

module spuVoice import spu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_tick,
	input  sample_t   i_noise,
	input  logic      i_keyOn,
	input  logic      i_keyOff,
	input  volume_t   i_volL,
	input  volume_t   i_volR,
	input  envLevel_t i_attackStep,
	input  envLevel_t i_releaseStep,
	output sample_t   o_sampleL,
	output sample_t   o_sampleR,
	output logic      o_valid
);

	localparam envLevel_t ENV_FULL = envLevel_t'(`SPU_ENV_MAX);

	envState_t          state;
	envLevel_t          level;
	logic [15:0]        attackSum;
	logic signed [31:0] envProd, prodL, prodR;
	sample_t            envScaled;

	// Noise scaled by envelope with the level always positive
	assign envProd   = i_noise * $signed({1'b0, level});
	assign envScaled = sample_t'(envProd >>> 15);
	assign prodL     = envScaled * i_volL;
	assign prodR     = envScaled * i_volR;

	// One extra bit so the attack overflow is visible
	assign attackSum = {1'b0, level} + {1'b0, i_attackStep};

	// Samples use the level from before this tick's envelope update
	always_ff @(posedge i_clk)
	begin
		if (i_tick)
		begin
			o_sampleL <= sample_t'(prodL >>> 15);
			o_sampleR <= sample_t'(prodR >>> 15);
		end
	end

	// ----------------------------------------------------------------------
	// Envelope FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			state   <= ENV_OFF;
			level   <= '0;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_tick;
			// Key on restarts from silence and wins over key off
			if (i_keyOn)
			begin
				state <= ENV_ATTACK;
				level <= '0;
			end
			else if (i_keyOff)
				state <= ENV_RELEASE;
			else if (i_tick)
			begin
				case (state)
					ENV_ATTACK:
					begin
						if (attackSum >= {1'b0, ENV_FULL})
						begin
							level <= ENV_FULL;
							state <= ENV_SUSTAIN;
						end
						else
							level <= attackSum[14:0];
					end
					ENV_RELEASE:
					begin
						if (level <= i_releaseStep)
						begin
							level <= '0;
							state <= ENV_OFF;
						end
						else
							level <= level - i_releaseStep;
					end
					default: ;   // Off and sustain hold their level
				endcase
			end
		end
	end

	// Attack climbs to the full level without wrapping past it
	aAttackNoWrap: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_tick && !i_keyOn && !i_keyOff && state == ENV_ATTACK)
		|=> (level >= $past(level)))
		else $error("spuVoice: attack level wrapped to %0d", level);

	// An idle voice is fully silent
	aIdleSilent: assert property (@(posedge i_clk) disable iff (i_rst)
		(state != ENV_OFF) || (level == '0))
		else $error("spuVoice: level %0d left over in state %s", level, state.name());

endmodule

// ==== rtl/spu_pkg.sv ====
// Sound processor shared types for samples, volumes, envelopes and register indices
`include "spu_settings.svh"

package spu_pkg;

	// Signed audio sample as seen by the mixer and the DAC
	typedef logic signed [15:0] sample_t;

	// Signed volume, 1.15 fixed point
	// Scaling is always multiply then arithmetic shift right by 15
	typedef logic signed [15:0] volume_t;

	// Unsigned envelope level, 0 up to SPU_ENV_MAX
	typedef logic [14:0] envLevel_t;

	// Reduced ADSR, linear attack and release only
	typedef enum logic [1:0]
	{
		ENV_OFF,
		ENV_ATTACK,
		ENV_SUSTAIN,
		ENV_RELEASE
	} envState_t;

	// Half-word register index on the CPU port
	typedef logic [`SPU_ADDR_W-1:0] regIndex_t;

endpackage

// ==== rtl/spu_settings.svh ====
// Sound processor build settings for voice count, sample timing and the register map
`ifndef SPU_SETTINGS_SVH
`define SPU_SETTINGS_SVH

// Number of voices in the generate loop
`define SPU_VOICES        4

// Clock cycles per stereo output sample (kept short for simulation)
`define SPU_SAMPLE_PERIOD 64

// Half-word register index width
`define SPU_ADDR_W        6

// Full envelope level, 15 bit unsigned
`define SPU_ENV_MAX       32767

// Global register indices, voice v owns 4v..4v+3
`define SPU_REG_KEYON     32
`define SPU_REG_KEYOFF    33
`define SPU_REG_NOISE     34
`define SPU_REG_MAINL     35
`define SPU_REG_MAINR     36

`endif

// ==== test/tbSpuTasks.svh ====
// Sound processor directed tests and CPU register access tasks for the testbench
`ifndef TB_SPU_TASKS_SVH
`define TB_SPU_TASKS_SVH

// Wait for n more output samples and return just after a rising edge
task automatic waitSamples(input int n);
	int target;
	int cycles;
	target = sampleCount + n;
	cycles = 0;
	while (sampleCount < target && cycles < (n + 1) * `SPU_SAMPLE_PERIOD + 8)
	begin
		@(posedge clk);
		cycles++;
	end
	if (sampleCount < target)
	begin
		$display("No output sample arrived within %0d cycles at %0t", cycles, $time);
		miscErrors++;
	end
endtask

task automatic writeReg(input int a, input logic [15:0] d);
	@(posedge clk);
	#DRIVE_NS;
	cs     = 1'b1;
	wr     = 1'b1;
	addr   = regIndex_t'(a);
	dataIn = d;
	recordWrite(a, d);
	@(posedge clk);
	#DRIVE_NS;
	cs = 1'b0;
	wr = 1'b0;
endtask

// Read strobe for one cycle with the answer due on the following cycle only
task automatic readCheck(input int a);
	logic [15:0] exp;
	exp = expectedRead(a);
	@(posedge clk);
	#DRIVE_NS;
	cs   = 1'b1;
	rd   = 1'b1;
	addr = regIndex_t'(a);
	@(posedge clk);
	#DRIVE_NS;
	cs = 1'b0;
	rd = 1'b0;
	if (dataOutValid !== 1'b1)
	begin
		$display("[ERROR] %0t o_dataOutValid expected 1 got %b", $time, dataOutValid);
		busErrors++;
	end
	else if (dataOut !== exp)
	begin
		$display("[ERROR] %0t o_dataOut index %0d expected %h got %h", $time, a, exp, dataOut);
		busErrors++;
	end
	@(posedge clk);
	#DRIVE_NS;
	if (dataOutValid !== 1'b0)
	begin
		$display("[ERROR] %0t o_dataOutValid expected 0 got %b", $time, dataOutValid);
		busErrors++;
	end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------

// First sample timing and zero output with no voice keyed
task automatic silenceAfterReset();
	int n;
	n = 0;
	while (!validOut && n < 2 * `SPU_SAMPLE_PERIOD)
	begin
		@(posedge clk);
		#1;
		n++;
	end
	if (n != `SPU_SAMPLE_PERIOD + 2)
	begin
		$display("[ERROR] %0t first o_validOut cycle expected %0d got %0d", $time,
			`SPU_SAMPLE_PERIOD + 2, n);
		miscErrors++;
	end
	for (int i = 0; i < LEN_SILENCE; i++)
	begin
		waitSamples(1);
		if (lastL !== 16'sd0 || lastR !== 16'sd0)
		begin
			$display("[ERROR] %0t o_aoutL/o_aoutR expected 0/0 got %0d/%0d", $time,
				lastL, lastR);
			sampleErrors++;
		end
	end
endtask

// Random words on every register in one batch per sample period
task automatic registerReadBack();
	logic [15:0] keyMask;
	keyMask = ~16'((1 << `SPU_VOICES) - 1);
	for (int v = 0; v < `SPU_VOICES; v++)
	begin
		waitSamples(1);
		for (int r = 0; r < 4; r++)
		begin
			writeReg(4 * v + r, randBits(16));
			readCheck(4 * v + r);
		end
	end
	waitSamples(1);
	// Voice bits cleared so no envelope starts here
	writeReg(`SPU_REG_KEYON, randBits(16) & keyMask);
	readCheck(`SPU_REG_KEYON);
	writeReg(`SPU_REG_KEYOFF, randBits(16) & keyMask);
	readCheck(`SPU_REG_KEYOFF);
	for (int a = `SPU_REG_NOISE; a <= `SPU_REG_MAINR; a++)
	begin
		writeReg(a, randBits(16));
		readCheck(a);
	end
	readCheck(40);
	readCheck((1 << `SPU_ADDR_W) - 1);
endtask

// Voice 0 alone through attack, sustain and release
task automatic envelopeOneVoice();
	bit heard;
	heard = 1'b0;
	waitSamples(1);
	writeReg(`SPU_REG_MAINL, 16'h7FFF);
	writeReg(`SPU_REG_MAINR, 16'h7FFF);
	writeReg(`SPU_REG_NOISE, 16'h0000);
	writeReg(0, 16'h7FFF);
	writeReg(1, 16'h7FFF);
	writeReg(2, 16'd1024 + randBits(12));
	writeReg(3, 16'd1024 + randBits(12));
	writeReg(`SPU_REG_KEYON, 16'h0001);
	for (int i = 0; i < 34; i++)
	begin
		waitSamples(1);
		if (lastL != 0 || lastR != 0)
			heard = 1'b1;
	end
	if (!heard)
	begin
		$display("Voice 0 stayed silent through its attack at %0t", $time);
		miscErrors++;
	end
	writeReg(`SPU_REG_KEYOFF, 16'h0001);
	waitSamples(36);
	if (lastL !== 16'sd0 || lastR !== 16'sd0)
	begin
		$display("[ERROR] %0t o_aoutL/o_aoutR after release expected 0/0 got %0d/%0d",
			$time, lastL, lastR);
		sampleErrors++;
	end
	waitSamples(1);
endtask

// Voice 0 held at full level while the divider changes
task automatic noiseDividerSweep();
	int divs [3];
	divs = '{0, 2, 5};
	waitSamples(1);
	writeReg(2, 16'h7FFF);
	writeReg(`SPU_REG_KEYON, 16'h0001);
	for (int i = 0; i < 3; i++)
	begin
		waitSamples(1);
		writeReg(`SPU_REG_NOISE, 16'(divs[i]));
		waitSamples(16);
	end
endtask

// All voices at full volume and later at half main volume
task automatic mixFourVoices();
	int hitsBefore;
	hitsBefore = clampHits;
	waitSamples(1);
	for (int v = 0; v < `SPU_VOICES; v++)
	begin
		writeReg(4 * v, 16'h7FFF);
		writeReg(4 * v + 1, 16'h7FFF);
		writeReg(4 * v + 2, 16'h7FFF);
	end
	writeReg(`SPU_REG_KEYON, 16'((1 << `SPU_VOICES) - 1));
	waitSamples(8);
	writeReg(`SPU_REG_MAINL, 16'h4000);
	writeReg(`SPU_REG_MAINR, 16'h4000);
	waitSamples(9);
	if (clampHits == hitsBefore)
	begin
		$display("The four voice sum never reached the clamp limits at %0t", $time);
		miscErrors++;
	end
endtask

`endif

// ==== test/tbSpu.sv ====
// Sound processor testbench with clock, reset, reference model, watchdog and summary
`include "spu_settings.svh"

module tbSpu import spu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_NS       = 40;
	localparam int          DRIVE_NS     = 2;
	localparam int          RESET_CYCLES = 8;
	localparam int          NUM_REGS     = 4 * `SPU_VOICES;
	localparam int          ENV_MAX      = `SPU_ENV_MAX;
	localparam logic [15:0] LFSR_SEED    = 16'd66;

	// Test lengths in output samples
	localparam int LEN_SILENCE = 6;
	localparam int LEN_REGS    = 6;
	localparam int LEN_ENV     = 72;
	localparam int LEN_NOISE   = 52;
	localparam int LEN_MIX     = 18;
	localparam int TOTAL       = LEN_SILENCE + LEN_REGS + LEN_ENV + LEN_NOISE + LEN_MIX;
	localparam int MARGIN_NS   = 50000;
	localparam int WATCHDOG_NS = (TOTAL + 4) * `SPU_SAMPLE_PERIOD * CLK_NS + MARGIN_NS;

	logic        clk, rst;
	logic        cs, rd, wr;
	regIndex_t   addr;
	logic [15:0] dataIn, dataOut;
	logic        dataOutValid, validOut;
	sample_t     aoutL, aoutR;

	int          sampleErrors = 0;
	int          busErrors    = 0;
	int          miscErrors   = 0;
	int          sampleCount  = 0;
	int          clampHits    = 0;
	int          cycleCount   = 0;
	int          lastValid    = -1;
	sample_t     lastL, lastR;
	logic [15:0] lfsrState    = LFSR_SEED;

	// Shadow of every register as written by the CPU tasks
	logic [15:0] shVoice [NUM_REGS];
	logic [15:0] shKeyOn, shKeyOff, shNoise, shMainL, shMainR;

	// Reference model state as it stands just before the next tick
	logic [15:0] mNoise, mDivCnt;
	envState_t   mState [`SPU_VOICES];
	int          mLevel [`SPU_VOICES];

	spuTop DUT
	(
		.i_clk          (clk),
		.i_rst          (rst),
		.i_cs           (cs),
		.i_rd           (rd),
		.i_wr           (wr),
		.i_addr         (addr),
		.i_dataIn       (dataIn),
		.o_dataOut      (dataOut),
		.o_dataOutValid (dataOutValid),
		.o_aoutL        (aoutL),
		.o_aoutR        (aoutR),
		.o_validOut     (validOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Stimulus helpers and reference model
	// ----------------------------------------------------------------------

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r         = {r[14:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return r;
	endfunction

	// Multiply then arithmetic shift by 15 with the result kept to 16 bits
	function automatic int mulShift15(input int a, input int b);
		int p;
		p = a * b;
		return int'(shortint'(p >>> 15));
	endfunction

	function automatic int clampSum(input int s);
		if (s > 32767)
			return 32767;
		if (s < -32768)
			return -32768;
		return s;
	endfunction

	// Track a CPU write where key bits act on the model right away
	function automatic void recordWrite(input int a, input logic [15:0] d);
		if (a < NUM_REGS)
			shVoice[a] = d;
		else if (a == `SPU_REG_KEYON)
		begin
			shKeyOn = d;
			for (int v = 0; v < `SPU_VOICES; v++)
				if (d[v])
				begin
					mState[v] = ENV_ATTACK;
					mLevel[v] = 0;
				end
		end
		else if (a == `SPU_REG_KEYOFF)
		begin
			shKeyOff = d;
			for (int v = 0; v < `SPU_VOICES; v++)
				if (d[v])
					mState[v] = ENV_RELEASE;
		end
		else if (a == `SPU_REG_NOISE)
			shNoise = d;
		else if (a == `SPU_REG_MAINL)
			shMainL = d;
		else if (a == `SPU_REG_MAINR)
			shMainR = d;
	endfunction

	// Unmapped indices read zero
	function automatic logic [15:0] expectedRead(input int a);
		if (a < NUM_REGS)
			return shVoice[a];
		case (a)
			`SPU_REG_KEYON:  return shKeyOn;
			`SPU_REG_KEYOFF: return shKeyOff;
			`SPU_REG_NOISE:  return shNoise;
			`SPU_REG_MAINL:  return shMainL;
			`SPU_REG_MAINR:  return shMainR;
			default:         return 16'h0000;
		endcase
	endfunction

	// Compare one output sample with the mix of the current model state
	function automatic void checkSample();
		int noise, es, sumL, sumR, clL, clR, expL, expR;
		noise = $signed(mNoise);
		sumL  = 0;
		sumR  = 0;
		for (int v = 0; v < `SPU_VOICES; v++)
		begin
			es   = mulShift15(noise, mLevel[v]);
			sumL = sumL + mulShift15(es, $signed(shVoice[4*v]));
			sumR = sumR + mulShift15(es, $signed(shVoice[4*v+1]));
		end
		clL = clampSum(sumL);
		clR = clampSum(sumR);
		if (clL != sumL || clR != sumR)
			clampHits++;
		expL = mulShift15(clL, $signed(shMainL));
		expR = mulShift15(clR, $signed(shMainR));
		if (aoutL !== sample_t'(expL))
		begin
			$display("[ERROR] %0t o_aoutL expected %0d got %0d", $time, expL, aoutL);
			sampleErrors++;
		end
		if (aoutR !== sample_t'(expR))
		begin
			$display("[ERROR] %0t o_aoutR expected %0d got %0d", $time, expR, aoutR);
			sampleErrors++;
		end
	endfunction

	// Envelope update and noise divider step once per tick
	function automatic void advanceModel();
		int atk, rel;
		for (int v = 0; v < `SPU_VOICES; v++)
		begin
			atk = shVoice[4*v+2][14:0];
			rel = shVoice[4*v+3][14:0];
			case (mState[v])
				ENV_ATTACK:
				begin
					mLevel[v] = mLevel[v] + atk;
					if (mLevel[v] >= ENV_MAX)
					begin
						mLevel[v] = ENV_MAX;
						mState[v] = ENV_SUSTAIN;
					end
				end
				ENV_RELEASE:
				begin
					mLevel[v] = (mLevel[v] <= rel) ? 0 : mLevel[v] - rel;
					if (mLevel[v] == 0)
						mState[v] = ENV_OFF;
				end
				default: ;
			endcase
		end
		if (mDivCnt >= shNoise)
		begin
			mDivCnt = '0;
			mNoise  = {mNoise[14:0], ~(mNoise[15] ^ mNoise[12] ^ mNoise[11] ^ mNoise[10])};
		end
		else
			mDivCnt = mDivCnt + 16'd1;
	endfunction

	// Output monitor checking spacing and value of every sample
	always @(negedge clk)
	begin
		cycleCount++;
		if (!rst && validOut)
		begin
			if (lastValid >= 0 && cycleCount - lastValid != `SPU_SAMPLE_PERIOD)
			begin
				$display("[ERROR] %0t o_validOut spacing expected %0d got %0d", $time,
					`SPU_SAMPLE_PERIOD, cycleCount - lastValid);
				sampleErrors++;
			end
			lastValid = cycleCount;
			lastL     = aoutL;
			lastR     = aoutR;
			checkSample();
			advanceModel();
			sampleCount++;
		end
	end

	`include "tbSpuTasks.svh"

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		cs       = 1'b0;
		rd       = 1'b0;
		wr       = 1'b0;
		addr     = '0;
		dataIn   = '0;
		rst      = 1'b1;
		shKeyOn  = '0;
		shKeyOff = '0;
		shNoise  = '0;
		shMainL  = '0;
		shMainR  = '0;
		mNoise   = '0;
		mDivCnt  = '0;
		for (int i = 0; i < NUM_REGS; i++)
			shVoice[i] = '0;
		for (int v = 0; v < `SPU_VOICES; v++)
		begin
			mState[v] = ENV_OFF;
			mLevel[v] = 0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_NS rst = 1'b0;

		silenceAfterReset();
		registerReadBack();
		envelopeOneVoice();
		noiseDividerSweep();
		mixFourVoices();
		waitSamples(2);

		$display("Summary: %0d sample errors, %0d bus errors, %0d other errors",
			sampleErrors, busErrors, miscErrors);
		if (sampleErrors + busErrors + miscErrors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Bound on the whole run from the summed test lengths
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule
